// ==== branchUnit.sv ====
/*
 * branch condition and next fetch address
 */
`timescale 1ns/1ps

module branchUnit (
	input  idPkg::wordT instr,
	input  idPkg::wordT pca,
	input  idPkg::wordT opA,
	input  idPkg::wordT opB,
	input  logic        jump,
	input  logic        jumpReg,
	input  logic        branch,
	output logic        taken,
	output idPkg::wordT nextAddr
);

	idPkg::wordT brOffset;
	idPkg::wordT brTarget;
	idPkg::wordT jTarget;
	logic        cond;
	logic        aZero;

	assign brOffset = {{14{instr[15]}}, instr[15:0], 2'b00};
	assign brTarget = pca + brOffset;
	assign jTarget  = {pca[31:28], instr[25:0], 2'b00};  // same 256MB region
	assign aZero    = (opA == '0);

	always_comb begin
		case (instr[idPkg::OP_LSB +: 6])
			idPkg::OP_BEQ:  cond = (opA == opB);
			idPkg::OP_BNE:  cond = (opA != opB);
			idPkg::OP_BLEZ: cond = opA[31] | aZero;
			idPkg::OP_BGTZ: cond = !opA[31] && !aZero;
			idPkg::OP_REGIMM: begin
				// bltz on sign bit set, bgez on sign bit clear
				if (instr[idPkg::RT_LSB +: 5] == idPkg::RT_BLTZ)
					cond = opA[31];
				else
					cond = !opA[31];
			end
			default: cond = 1'b0;
		endcase
	end

	assign taken = jump | (branch & cond);

	// -------------------------------------------------
	// next address, jr/jalr first
	// -------------------------------------------------
	always_comb begin
		if (jumpReg)
			nextAddr = opA;
		else if (jump)
			nextAddr = jTarget;
		else if (taken)
			nextAddr = brTarget;
		else
			nextAddr = pca;
	end

endmodule

// ==== files.f ====
idPkg.sv
regFile.sv
idControl.sv
branchUnit.sv
idExReg.sv
idStage.sv
idStage_tb.sv

// ==== idControl.sv ====
/*
 * main control decoder for the integer subset
 * instruction word to control levels, ALU code and destination register
 */
`timescale 1ns/1ps

module idControl (
	input  idPkg::wordT    instr,
	output logic           link,
	output logic           regDst,
	output logic           jump,
	output logic           jumpReg,
	output logic           branch,
	output logic           memRead,
	output logic           memToReg,
	output logic           memWrite,
	output logic           aluSrc,
	output logic           regWrite,
	output idPkg::aluCtrlT aluCtrl,
	output idPkg::regAddrT writeReg
);

	logic [5:0] opcode;
	logic [5:0] funct;
	logic [4:0] rtField;

	assign opcode  = instr[idPkg::OP_LSB +: 6];
	assign funct   = instr[5:0];
	assign rtField = instr[idPkg::RT_LSB +: 5];

	always_comb begin
		// unknown encodings fall through as a no-op
		link     = 1'b0;
		regDst   = 1'b0;
		jump     = 1'b0;
		jumpReg  = 1'b0;
		branch   = 1'b0;
		memRead  = 1'b0;
		memToReg = 1'b0;
		memWrite = 1'b0;
		aluSrc   = 1'b0;
		regWrite = 1'b0;
		aluCtrl  = idPkg::ALU_ADD;

		case (opcode)
			idPkg::OP_SPECIAL: begin
				regDst   = 1'b1;  // register ALU ops write rd
				regWrite = 1'b1;
				case (funct)
					idPkg::FN_SLL:  aluCtrl = idPkg::ALU_SLL;
					idPkg::FN_SRL:  aluCtrl = idPkg::ALU_SRL;
					idPkg::FN_SRA:  aluCtrl = idPkg::ALU_SRA;
					idPkg::FN_SLLV: aluCtrl = idPkg::ALU_SLLV;
					idPkg::FN_SRLV: aluCtrl = idPkg::ALU_SRLV;
					idPkg::FN_SRAV: aluCtrl = idPkg::ALU_SRAV;
					idPkg::FN_ADD:  aluCtrl = idPkg::ALU_ADD;
					idPkg::FN_ADDU: aluCtrl = idPkg::ALU_ADDU;
					idPkg::FN_SUB:  aluCtrl = idPkg::ALU_SUB;
					idPkg::FN_SUBU: aluCtrl = idPkg::ALU_SUBU;
					idPkg::FN_AND:  aluCtrl = idPkg::ALU_AND;
					idPkg::FN_OR:   aluCtrl = idPkg::ALU_OR;
					idPkg::FN_XOR:  aluCtrl = idPkg::ALU_XOR;
					idPkg::FN_NOR:  aluCtrl = idPkg::ALU_NOR;
					idPkg::FN_SLT:  aluCtrl = idPkg::ALU_SLT;
					idPkg::FN_SLTU: aluCtrl = idPkg::ALU_SLTU;
					idPkg::FN_JR: begin
						regDst   = 1'b0;
						regWrite = 1'b0;
						jump     = 1'b1;
						jumpReg  = 1'b1;
					end
					idPkg::FN_JALR: begin
						regDst  = 1'b0;  // return address goes to $31
						link    = 1'b1;
						jump    = 1'b1;
						jumpReg = 1'b1;
					end
					default: begin
						regDst   = 1'b0;
						regWrite = 1'b0;
					end
				endcase
			end
			idPkg::OP_REGIMM: begin
				branch = (rtField == idPkg::RT_BLTZ) || (rtField == idPkg::RT_BGEZ);
			end
			idPkg::OP_J: jump = 1'b1;
			idPkg::OP_JAL: begin
				jump     = 1'b1;
				link     = 1'b1;
				regWrite = 1'b1;
			end
			idPkg::OP_BEQ, idPkg::OP_BNE, idPkg::OP_BLEZ, idPkg::OP_BGTZ: branch = 1'b1;

			// -------------------------------------------------
			// immediates, loads and stores
			// -------------------------------------------------
			idPkg::OP_ADDI, idPkg::OP_ADDIU, idPkg::OP_SLTI, idPkg::OP_SLTIU,
			idPkg::OP_ANDI, idPkg::OP_ORI, idPkg::OP_XORI, idPkg::OP_LUI: begin
				aluSrc   = 1'b1;
				regWrite = 1'b1;
				case (opcode)
					idPkg::OP_ADDIU: aluCtrl = idPkg::ALU_ADDU;
					idPkg::OP_SLTI:  aluCtrl = idPkg::ALU_SLT;
					idPkg::OP_SLTIU: aluCtrl = idPkg::ALU_SLTU;
					idPkg::OP_ANDI:  aluCtrl = idPkg::ALU_AND;
					idPkg::OP_ORI:   aluCtrl = idPkg::ALU_OR;
					idPkg::OP_XORI:  aluCtrl = idPkg::ALU_XOR;
					idPkg::OP_LUI:   aluCtrl = idPkg::ALU_LUI;
					default:         aluCtrl = idPkg::ALU_ADD;  // addi
				endcase
			end
			idPkg::OP_LB, idPkg::OP_LH, idPkg::OP_LW, idPkg::OP_LBU, idPkg::OP_LHU: begin
				memRead  = 1'b1;
				memToReg = 1'b1;
				aluSrc   = 1'b1;  // address = rs + offset
				regWrite = 1'b1;
			end
			idPkg::OP_SB, idPkg::OP_SH, idPkg::OP_SW: begin
				memWrite = 1'b1;
				aluSrc   = 1'b1;
			end
			default: ;
		endcase
	end

	// rd, else $31 for links, else rt
	assign writeReg = regDst ? instr[idPkg::RD_LSB +: 5]
		: (link ? idPkg::LINK_REG : instr[idPkg::RT_LSB +: 5]);

endmodule

// ==== idExReg.sv ====
/*
 * ID/EX pipeline register
 * link operand substitution, held while freeze is high
 */
`timescale 1ns/1ps

module idExReg (
	input  logic           CLK,
	input  logic           RESET,
	input  logic           freeze,
	input  idPkg::wordT    instr,
	input  idPkg::wordT    pca,
	input  idPkg::wordT    rsData,
	input  idPkg::wordT    rtData,
	input  idPkg::wordT    destData,
	input  logic           link,
	input  logic           memRead,
	input  logic           memToReg,
	input  logic           memWrite,
	input  logic           aluSrc,
	input  logic           regWrite,
	input  idPkg::aluCtrlT aluCtrl,
	input  idPkg::regAddrT writeReg,
	input  logic           taken,
	output idPkg::wordT    instrQ,
	output idPkg::wordT    operandA,
	output idPkg::wordT    operandB,
	output idPkg::wordT    readDataA,
	output idPkg::wordT    readDataB,
	output idPkg::wordT    destValue,
	output idPkg::regAddrT readRegA,
	output idPkg::regAddrT readRegB,
	output idPkg::regAddrT writeRegQ,
	output idPkg::shamtT   shamt,
	output idPkg::immT     imm,
	output idPkg::aluCtrlT aluCtrlQ,
	output logic           aluSrcQ,
	output logic           memReadQ,
	output logic           memWriteQ,
	output logic           memToRegQ,
	output logic           doWriteback,
	output logic           takenQ
);

	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			instrQ      <= '0;
			operandA    <= '0;
			operandB    <= '0;
			readDataA   <= '0;
			readDataB   <= '0;
			destValue   <= '0;
			readRegA    <= '0;
			readRegB    <= '0;
			writeRegQ   <= '0;
			shamt       <= '0;
			imm         <= '0;
			aluCtrlQ    <= idPkg::ALU_ADD;
			aluSrcQ     <= 1'b0;
			memReadQ    <= 1'b0;
			memWriteQ   <= 1'b0;
			memToRegQ   <= 1'b0;
			doWriteback <= 1'b0;
			takenQ      <= 1'b0;
		end else if (!freeze) begin
			instrQ    <= instr;
			// links compute pc+4 + 0 + 4 ... return address in the ALU
			operandA  <= link ? pca : rsData;
			operandB  <= link ? idPkg::LINK_OFFSET : rtData;
			readDataA <= rsData;
			readDataB <= rtData;
			destValue <= destData;
			readRegA  <= link ? '0 : instr[idPkg::RS_LSB +: 5];
			readRegB  <= (link || aluSrc) ? '0 : instr[idPkg::RT_LSB +: 5];
			writeRegQ <= writeReg;
			shamt     <= instr[idPkg::SH_LSB +: 5];
			imm       <= instr[15:0];
			aluCtrlQ  <= aluCtrl;
			aluSrcQ   <= aluSrc;
			memReadQ  <= memRead;
			memWriteQ <= memWrite;
			memToRegQ <= memToReg;
			doWriteback <= regWrite | memToReg;
			takenQ    <= taken;
		end
	end

endmodule

// ==== idPkg.sv ====
/*
 * MIPS decode stage shared definitions
 * word and field types, opcode, funct and ALU-control encodings
 */
package idPkg;

	// -------------------------------------------------
	// widths and instruction field positions
	// -------------------------------------------------
	localparam int WORD_W = 32;
	localparam int REG_AW = 5;
	localparam int OP_LSB = 26;
	localparam int RS_LSB = 21;
	localparam int RT_LSB = 16;
	localparam int RD_LSB = 11;
	localparam int SH_LSB = 6;

	typedef logic [WORD_W-1:0] wordT;    // data, instruction, address
	typedef logic [REG_AW-1:0] regAddrT;
	typedef logic [5:0]        aluCtrlT;
	typedef logic [15:0]       immT;
	typedef logic [4:0]        shamtT;

	localparam int      NUM_REGS    = 32;
	localparam regAddrT LINK_REG    = 5'd31;
	localparam wordT    LINK_OFFSET = 32'd4;  // operand B on jal/jalr

	// -------------------------------------------------
	// primary opcodes
	// -------------------------------------------------
	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_REGIMM  = 6'h01;
	localparam logic [5:0] OP_J       = 6'h02;
	localparam logic [5:0] OP_JAL     = 6'h03;
	localparam logic [5:0] OP_BEQ     = 6'h04;
	localparam logic [5:0] OP_BNE     = 6'h05;
	localparam logic [5:0] OP_BLEZ    = 6'h06;
	localparam logic [5:0] OP_BGTZ    = 6'h07;
	localparam logic [5:0] OP_ADDI    = 6'h08;
	localparam logic [5:0] OP_ADDIU   = 6'h09;
	localparam logic [5:0] OP_SLTI    = 6'h0a;
	localparam logic [5:0] OP_SLTIU   = 6'h0b;
	localparam logic [5:0] OP_ANDI    = 6'h0c;
	localparam logic [5:0] OP_ORI     = 6'h0d;
	localparam logic [5:0] OP_XORI    = 6'h0e;
	localparam logic [5:0] OP_LUI     = 6'h0f;
	localparam logic [5:0] OP_LB      = 6'h20;
	localparam logic [5:0] OP_LH      = 6'h21;
	localparam logic [5:0] OP_LW      = 6'h23;
	localparam logic [5:0] OP_LBU     = 6'h24;
	localparam logic [5:0] OP_LHU     = 6'h25;
	localparam logic [5:0] OP_SB      = 6'h28;
	localparam logic [5:0] OP_SH      = 6'h29;
	localparam logic [5:0] OP_SW      = 6'h2b;

	// SPECIAL funct field
	localparam logic [5:0] FN_SLL  = 6'h00;
	localparam logic [5:0] FN_SRL  = 6'h02;
	localparam logic [5:0] FN_SRA  = 6'h03;
	localparam logic [5:0] FN_SLLV = 6'h04;
	localparam logic [5:0] FN_SRLV = 6'h06;
	localparam logic [5:0] FN_SRAV = 6'h07;
	localparam logic [5:0] FN_JR   = 6'h08;
	localparam logic [5:0] FN_JALR = 6'h09;
	localparam logic [5:0] FN_ADD  = 6'h20;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUB  = 6'h22;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_XOR  = 6'h26;
	localparam logic [5:0] FN_NOR  = 6'h27;
	localparam logic [5:0] FN_SLT  = 6'h2a;
	localparam logic [5:0] FN_SLTU = 6'h2b;

	localparam logic [4:0] RT_BLTZ = 5'h00;  // REGIMM rt field
	localparam logic [4:0] RT_BGEZ = 5'h01;

	// -------------------------------------------------
	// ALU operation codes sent to execute
	// -------------------------------------------------
	localparam aluCtrlT ALU_ADD  = 6'd0;
	localparam aluCtrlT ALU_ADDU = 6'd1;
	localparam aluCtrlT ALU_SUB  = 6'd2;
	localparam aluCtrlT ALU_SUBU = 6'd3;
	localparam aluCtrlT ALU_AND  = 6'd4;
	localparam aluCtrlT ALU_OR   = 6'd5;
	localparam aluCtrlT ALU_XOR  = 6'd6;
	localparam aluCtrlT ALU_NOR  = 6'd7;
	localparam aluCtrlT ALU_SLT  = 6'd8;
	localparam aluCtrlT ALU_SLTU = 6'd9;
	localparam aluCtrlT ALU_SLL  = 6'd10;
	localparam aluCtrlT ALU_SRL  = 6'd11;
	localparam aluCtrlT ALU_SRA  = 6'd12;
	localparam aluCtrlT ALU_SLLV = 6'd13;
	localparam aluCtrlT ALU_SRLV = 6'd14;
	localparam aluCtrlT ALU_SRAV = 6'd15;
	localparam aluCtrlT ALU_LUI  = 6'd16;

endpackage

// ==== idStage.sv ====
/*
 * MIPS instruction decode stage top
 * register file, decoder, branch unit and ID/EX register
 */
`timescale 1ns/1ps

module idStage (
	input  logic           CLK,
	input  logic           RESET,
	input  logic           freeze,
	input  idPkg::wordT    instr,
	input  idPkg::wordT    pca,          // pc+4 of instr
	input  logic           wbWe,
	input  idPkg::regAddrT wbAddr,
	input  idPkg::wordT    wbData,
	output idPkg::wordT    nextAddr,
	output idPkg::wordT    instrQ,
	output idPkg::wordT    operandA,
	output idPkg::wordT    operandB,
	output idPkg::wordT    readDataA,
	output idPkg::wordT    readDataB,
	output idPkg::wordT    destValue,
	output idPkg::regAddrT readRegA,
	output idPkg::regAddrT readRegB,
	output idPkg::regAddrT writeRegQ,
	output idPkg::shamtT   shamt,
	output idPkg::immT     imm,
	output idPkg::aluCtrlT aluCtrlQ,
	output logic           aluSrcQ,
	output logic           memReadQ,
	output logic           memWriteQ,
	output logic           memToRegQ,
	output logic           doWriteback,
	output logic           takenQ
);

	idPkg::wordT    rsData;
	idPkg::wordT    rtData;
	idPkg::wordT    destData;
	idPkg::aluCtrlT aluCtrl;
	idPkg::regAddrT writeReg;
	logic           link;
	logic           jump;
	logic           jumpReg;
	logic           branch;
	logic           memRead;
	logic           memToReg;
	logic           memWrite;
	logic           aluSrc;
	logic           regWrite;
	logic           taken;

	// -------------------------------------------------
	// decode, same cycle
	// -------------------------------------------------
	regFile rf0 (
		.CLK    (CLK),
		.RESET  (RESET),
		.we     (wbWe),
		.wAddr  (wbAddr),
		.wData  (wbData),
		.rAddrA (instr[idPkg::RS_LSB +: 5]),
		.rAddrB (instr[idPkg::RT_LSB +: 5]),
		.rAddrD (writeReg),
		.rDataA (rsData),
		.rDataB (rtData),
		.rDataD (destData)
	);

	idControl ctl0 (
		.instr    (instr),
		.link     (link),
		.regDst   (),  // only steers writeReg inside the decoder
		.jump     (jump),
		.jumpReg  (jumpReg),
		.branch   (branch),
		.memRead  (memRead),
		.memToReg (memToReg),
		.memWrite (memWrite),
		.aluSrc   (aluSrc),
		.regWrite (regWrite),
		.aluCtrl  (aluCtrl),
		.writeReg (writeReg)
	);

	branchUnit bu0 (
		.instr    (instr),
		.pca      (pca),
		.opA      (rsData),
		.opB      (rtData),
		.jump     (jump),
		.jumpReg  (jumpReg),
		.branch   (branch),
		.taken    (taken),
		.nextAddr (nextAddr)
	);

	idExReg pr0 (
		.CLK         (CLK),
		.RESET       (RESET),
		.freeze      (freeze),
		.instr       (instr),
		.pca         (pca),
		.rsData      (rsData),
		.rtData      (rtData),
		.destData    (destData),
		.link        (link),
		.memRead     (memRead),
		.memToReg    (memToReg),
		.memWrite    (memWrite),
		.aluSrc      (aluSrc),
		.regWrite    (regWrite),
		.aluCtrl     (aluCtrl),
		.writeReg    (writeReg),
		.taken       (taken),
		.instrQ      (instrQ),
		.operandA    (operandA),
		.operandB    (operandB),
		.readDataA   (readDataA),
		.readDataB   (readDataB),
		.destValue   (destValue),
		.readRegA    (readRegA),
		.readRegB    (readRegB),
		.writeRegQ   (writeRegQ),
		.shamt       (shamt),
		.imm         (imm),
		.aluCtrlQ    (aluCtrlQ),
		.aluSrcQ     (aluSrcQ),
		.memReadQ    (memReadQ),
		.memWriteQ   (memWriteQ),
		.memToRegQ   (memToRegQ),
		.doWriteback (doWriteback),
		.takenQ      (takenQ)
	);

endmodule

// ==== idStage_tb.sv ====
/*
 * testbench for the MIPS decode stage
 * preloads registers, runs decode vectors from idTestdata.txt, checks ID/EX outputs
 */
`timescale 1ns/1ps

module idStage_tb;

	localparam int CLK_PERIOD = 40;
	localparam int FILL_CYCLES = 31;      // writes to $1..$31
	localparam int DIRECTED_CYCLES = 12;  // reset, cleared regs, $0 and freeze checks
	localparam int SLACK_CYCLES = 10;

	logic           CLK;
	logic           RESET;
	logic           freeze;
	idPkg::wordT    instr;
	idPkg::wordT    pca;
	logic           wbWe;
	idPkg::regAddrT wbAddr;
	idPkg::wordT    wbData;
	idPkg::wordT    nextAddr;
	idPkg::wordT    instrQ;
	idPkg::wordT    operandA;
	idPkg::wordT    operandB;
	idPkg::wordT    readDataA;
	idPkg::wordT    readDataB;
	idPkg::wordT    destValue;
	idPkg::regAddrT readRegA;
	idPkg::regAddrT readRegB;
	idPkg::regAddrT writeRegQ;
	idPkg::shamtT   shamt;
	idPkg::immT     imm;
	idPkg::aluCtrlT aluCtrlQ;
	logic           aluSrcQ;
	logic           memReadQ;
	logic           memWriteQ;
	logic           memToRegQ;
	logic           doWriteback;
	logic           takenQ;

	logic [239:0] regOuts;  // every registered output side by side
	logic [31:0]  model [32];
	logic [31:0]  lfsr;
	int           errors;
	int           numTests;
	bit           loaded;

	// vectors from the data file
	string       tName [$];
	logic [31:0] tInstr [$];
	logic [31:0] tPca [$];
	logic [31:0] tAlu [$];
	logic [31:0] tWr [$];
	logic [4:0]  tFlags [$];  // memRead, memWrite, memToReg, aluSrc, doWriteback

	idStage dut0 (
		.CLK         (CLK),
		.RESET       (RESET),
		.freeze      (freeze),
		.instr       (instr),
		.pca         (pca),
		.wbWe        (wbWe),
		.wbAddr      (wbAddr),
		.wbData      (wbData),
		.nextAddr    (nextAddr),
		.instrQ      (instrQ),
		.operandA    (operandA),
		.operandB    (operandB),
		.readDataA   (readDataA),
		.readDataB   (readDataB),
		.destValue   (destValue),
		.readRegA    (readRegA),
		.readRegB    (readRegB),
		.writeRegQ   (writeRegQ),
		.shamt       (shamt),
		.imm         (imm),
		.aluCtrlQ    (aluCtrlQ),
		.aluSrcQ     (aluSrcQ),
		.memReadQ    (memReadQ),
		.memWriteQ   (memWriteQ),
		.memToRegQ   (memToRegQ),
		.doWriteback (doWriteback),
		.takenQ      (takenQ)
	);

	assign regOuts = {instrQ, operandA, operandB, readDataA, readDataB, destValue,
		readRegA, readRegB, writeRegQ, shamt, imm, aluCtrlQ,
		aluSrcQ, memReadQ, memWriteQ, memToRegQ, doWriteback, takenQ};

	initial begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];  // x^32 + x^22 + x^2 + x + 1
		return {s[30:0], fb};
	endfunction

	task automatic drawWord(output logic [31:0] w);
		w = '0;
		for (int k = 0; k < 32; k++) begin
			lfsr = lfsrNext(lfsr);
			w = {w[30:0], lfsr[0]};
		end
	endtask

	function automatic logic isLink(input logic [31:0] ins);
		return (ins[31:26] == 6'h03) || (ins[31:26] == 6'h00 && ins[5:0] == 6'h09);
	endfunction

	// expected taken and next fetch address from the register model
	task automatic predictBranch(input logic [31:0] ins, input logic [31:0] pc4,
		output logic tk, output logic [31:0] nxt);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] off;
		logic        isJr;
		logic        isJ;
		logic        cond;
		a = model[ins[25:21]];
		b = model[ins[20:16]];
		off = {{14{ins[15]}}, ins[15:0], 2'b00};
		isJr = (ins[31:26] == 6'h00) && (ins[5:0] == 6'h08 || ins[5:0] == 6'h09);
		isJ = (ins[31:26] == 6'h02) || (ins[31:26] == 6'h03);
		case (ins[31:26])
			6'h04: cond = (a == b);
			6'h05: cond = (a != b);
			6'h06: cond = a[31] || (a == 0);
			6'h07: cond = !a[31] && (a != 0);
			6'h01: cond = (ins[20:16] == 5'd0) ? a[31] : ((ins[20:16] == 5'd1) && !a[31]);
			default: cond = 1'b0;
		endcase
		tk = isJr || isJ || cond;
		if (isJr)
			nxt = a;
		else if (isJ)
			nxt = {pc4[31:28], ins[25:0], 2'b00};
		else if (cond)
			nxt = pc4 + off;
		else
			nxt = pc4;
	endtask

	task automatic reportMismatch(input string testName, input string field,
		input logic [31:0] expected, input logic [31:0] actual);
		errors++;
		$display("FAILED %s %s: expected %h actual %h", testName, field, expected, actual);
	endtask

	// watchdog, sized from the number of vectors
	initial begin : watchdog
		int watchCycles;
		wait (loaded);
		watchCycles = numTests + FILL_CYCLES + DIRECTED_CYCLES + SLACK_CYCLES;
		#(watchCycles * CLK_PERIOD);
		$display("timeout, decode tests did not finish within %0d cycles", watchCycles);
		$display("Errors found");
		$finish;
	end

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial begin : mainSeq
		int          fd;
		int          n;
		string       line;
		string       nm;
		logic [31:0] ins;
		logic [31:0] pc;
		int          al;
		int          wr;
		int          mr;
		int          mw;
		int          m2r;
		int          as;
		int          dw;
		logic [31:0] cur;
		logic [31:0] expA;
		logic [31:0] expB;
		logic [31:0] expNext;
		logic        expTaken;
		logic        expLink;
		logic [4:0]  expRegA;
		logic [4:0]  expRegB;
		logic [4:0]  fl;
		logic [31:0] newVal;
		logic [239:0] snap;

		RESET = 1'b0;
		freeze = 1'b0;
		instr = '0;
		pca = '0;
		wbWe = 1'b0;
		wbAddr = '0;
		wbData = '0;
		errors = 0;
		numTests = 0;
		lfsr = 32'hf2aecd88;
		model[0] = '0;

		fd = $fopen("idTestdata.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open idTestdata.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (n > 0 && line.len() > 8 && line.getc(0) != "#") begin
					n = $sscanf(line, "%s %h %h %d %d %d %d %d %d %d",
						nm, ins, pc, al, wr, mr, mw, m2r, as, dw);
					if (n != 10) begin
						errors++;
						$display("malformed line in idTestdata.txt: %s", line);
					end else begin
						tName.push_back(nm);
						tInstr.push_back(ins);
						tPca.push_back(pc);
						tAlu.push_back(al);
						tWr.push_back(wr);
						tFlags.push_back({mr[0], mw[0], m2r[0], as[0], dw[0]});
					end
				end
			end
			$fclose(fd);
		end
		numTests = tName.size();
		loaded = 1'b1;

		// reset held 4 cycles, outputs checked while still in reset
		repeat (4) @(posedge CLK);
		@(negedge CLK);
		if (regOuts !== '0) begin
			errors++;
			$display("FAILED reset regOuts: expected %h actual %h", 240'h0, regOuts);
		end
		RESET = 1'b1;
		instr = 32'h00A62021;  // addu $4,$5,$6 on cleared registers
		@(posedge CLK);
		@(negedge CLK);
		if (operandA !== 32'd0) reportMismatch("clearedRegs", "operandA", 0, operandA);
		if (operandB !== 32'd0) reportMismatch("clearedRegs", "operandB", 0, operandB);

		// preload $1..$31 through the writeback port
		for (int r = 1; r < 32; r++) begin
			drawWord(newVal);
			model[r] = newVal;
			wbWe = 1'b1;
			wbAddr = r[4:0];
			wbData = newVal;
			@(negedge CLK);
		end
		wbWe = 1'b0;

		for (int i = 0; i < numTests; i++) begin
			cur = tInstr[i];
			instr = cur;
			pca = tPca[i];
			predictBranch(cur, tPca[i], expTaken, expNext);
			expLink = isLink(cur);
			expA = expLink ? tPca[i] : model[cur[25:21]];
			expB = expLink ? 32'd4 : model[cur[20:16]];
			fl = tFlags[i];
			expRegA = expLink ? 5'd0 : cur[25:21];
			expRegB = (expLink || fl[1]) ? 5'd0 : cur[20:16];  // no rt operand
			nm = tName[i];
			@(posedge CLK);
			@(negedge CLK);
			if (instrQ !== cur) reportMismatch(nm, "instrQ", cur, instrQ);
			if (aluCtrlQ !== tAlu[i][5:0]) reportMismatch(nm, "aluCtrl", tAlu[i], aluCtrlQ);
			if (writeRegQ !== tWr[i][4:0]) reportMismatch(nm, "writeReg", tWr[i], writeRegQ);
			if (memReadQ !== fl[4]) reportMismatch(nm, "memRead", fl[4], memReadQ);
			if (memWriteQ !== fl[3]) reportMismatch(nm, "memWrite", fl[3], memWriteQ);
			if (memToRegQ !== fl[2]) reportMismatch(nm, "memToReg", fl[2], memToRegQ);
			if (aluSrcQ !== fl[1]) reportMismatch(nm, "aluSrc", fl[1], aluSrcQ);
			if (doWriteback !== fl[0]) reportMismatch(nm, "doWriteback", fl[0], doWriteback);
			if (operandA !== expA) reportMismatch(nm, "operandA", expA, operandA);
			if (operandB !== expB) reportMismatch(nm, "operandB", expB, operandB);
			if (readDataA !== model[cur[25:21]])
				reportMismatch(nm, "readDataA", model[cur[25:21]], readDataA);
			if (readDataB !== model[cur[20:16]])
				reportMismatch(nm, "readDataB", model[cur[20:16]], readDataB);
			if (readRegA !== expRegA) reportMismatch(nm, "readRegA", expRegA, readRegA);
			if (readRegB !== expRegB) reportMismatch(nm, "readRegB", expRegB, readRegB);
			if (shamt !== cur[10:6]) reportMismatch(nm, "shamt", cur[10:6], shamt);
			if (imm !== cur[15:0]) reportMismatch(nm, "imm", cur[15:0], imm);
			if (destValue !== model[tWr[i][4:0]])
				reportMismatch(nm, "destValue", model[tWr[i][4:0]], destValue);
			if (takenQ !== expTaken) reportMismatch(nm, "taken", expTaken, takenQ);
			if (nextAddr !== expNext) reportMismatch(nm, "nextAddr", expNext, nextAddr);
		end

		// --------------------------------------------------
		// $0 stays zero, other writes reach the next decode
		// --------------------------------------------------
		wbWe = 1'b1;
		wbAddr = 5'd0;
		wbData = 32'hdeadbeef;
		instr = 32'h00001820;  // add $3,$0,$0
		pca = 32'h00400100;
		@(posedge CLK);
		@(negedge CLK);
		drawWord(newVal);
		model[5] = newVal;
		wbAddr = 5'd5;
		wbData = newVal;
		@(posedge CLK);
		@(negedge CLK);
		if (operandA !== 32'd0) reportMismatch("reg0", "operandA", 0, operandA);
		if (operandB !== 32'd0) reportMismatch("reg0", "operandB", 0, operandB);
		wbWe = 1'b0;
		instr = 32'h00A63825;  // or $7,$5,$6
		@(posedge CLK);
		@(negedge CLK);
		if (operandA !== model[5]) reportMismatch("writeback", "operandA", model[5], operandA);
		if (operandB !== model[6]) reportMismatch("writeback", "operandB", model[6], operandB);

		// freeze holds the ID/EX register
		instr = 32'h8F380008;  // lw $24,8($25)
		@(posedge CLK);
		@(negedge CLK);
		snap = regOuts;
		freeze = 1'b1;
		instr = 32'hACC5FFFC;  // sw $5,-4($6)
		@(posedge CLK);
		@(negedge CLK);
		if (regOuts !== snap) begin
			errors++;
			$display("FAILED freeze regOuts: expected %h actual %h", snap, regOuts);
		end
		freeze = 1'b0;
		@(posedge CLK);
		@(negedge CLK);
		if (instrQ !== 32'hACC5FFFC) reportMismatch("unfreeze", "instrQ", 32'hACC5FFFC, instrQ);
		if (memWriteQ !== 1'b1) reportMismatch("unfreeze", "memWrite", 1, memWriteQ);
		if (memReadQ !== 1'b0) reportMismatch("unfreeze", "memRead", 0, memReadQ);
		if (operandA !== model[6]) reportMismatch("unfreeze", "operandA", model[6], operandA);

		$display("%0d decode vectors, %0d errors", numTests, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// ==== idTestdata.txt ====
# name instr(hex) pca(hex) aluCtrl writeReg memRead memWrite memToReg aluSrc doWriteback
# aluCtrl and writeReg decimal, the rest single bits
add       00221820 00400004 0  3  0 0 0 0 1
subu      016C5023 00400008 3  10 0 0 0 0 1
and       01CF6824 0040000c 4  13 0 0 0 0 1
nor       02F8B027 00400010 7  22 0 0 0 0 1
sltu      03BEE02B 00400014 9  28 0 0 0 0 1
sll       00031140 00400018 10 2  0 0 0 0 1
srav      020F7007 0040001c 15 14 0 0 0 0 1
addi      20C5FFF8 00400020 0  5  0 0 0 1 1
sltiu     2D8BFFFF 00400024 9  11 0 0 0 1 1
ori       360FA5A5 00400028 5  15 0 0 0 1 1
lui       3C13BEEF 0040002c 16 19 0 0 0 1 1
lb        82B40004 00400030 0  20 1 0 1 1 1
lw        8F380008 00400034 0  24 1 0 1 1 1
sw        ACC5FFFC 00400038 0  5  0 1 0 1 0
beqSame   10E70003 0040003c 0  7  0 0 0 0 0
beqDiff   1109FFFE 00400040 0  9  0 0 0 0 0
bneSame   154A0005 00400044 0  10 0 0 0 0 0
bneDiff   156C0010 00400048 0  12 0 0 0 0 0
blezZero  18000002 0040004c 0  0  0 0 0 0 0
bgtz      1DC0FFFF 00400050 0  0  0 0 0 0 0
bltz      05E00009 00400054 0  0  0 0 0 0 0
bgez      0601FFFB 00400058 0  1  0 0 0 0 0
j         08123456 a0000010 0  18 0 0 0 0 0
jal       0C000100 00400060 0  31 0 0 0 0 1
jr        02200008 00400064 0  0  0 0 0 0 0
jalr      0240F809 00400068 0  31 0 0 0 0 1
badOp     FC000000 0040006c 0  0  0 0 0 0 0
badFunct  00221801 00400070 0  2  0 0 0 0 0

// ==== regFile.sv ====
/*
 * register file, 32 x 32 bit
 * one write port, three combinational read ports, $0 reads zero
 */
`timescale 1ns/1ps

module regFile (
	input  logic           CLK,
	input  logic           RESET,
	input  logic           we,
	input  idPkg::regAddrT wAddr,
	input  idPkg::wordT    wData,
	input  idPkg::regAddrT rAddrA,
	input  idPkg::regAddrT rAddrB,
	input  idPkg::regAddrT rAddrD,
	output idPkg::wordT    rDataA,
	output idPkg::wordT    rDataB,
	output idPkg::wordT    rDataD
);

	idPkg::wordT regs [idPkg::NUM_REGS];

	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			for (int i = 0; i < idPkg::NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (wAddr != '0)) begin  // writes to $0 dropped
			regs[wAddr] <= wData;
		end
	end

	// no bypass, a write shows up the cycle after its edge
	assign rDataA = (rAddrA == '0) ? '0 : regs[rAddrA];
	assign rDataB = (rAddrB == '0) ? '0 : regs[rAddrB];
	assign rDataD = (rAddrD == '0) ? '0 : regs[rAddrD];  // old dest value

endmodule
